//--- bottom_defs.svh
`ifndef BOTTOM_DEFS_SVH
`define BOTTOM_DEFS_SVH

// Byte register selects for loads and the two read ports
`define REG_NONE 4'd0
`define REG_B    4'd1
`define REG_C    4'd2
`define REG_D    4'd3
`define REG_E    4'd4
`define REG_H    4'd5
`define REG_L    4'd6
`define REG_A    4'd7
`define REG_W    4'd8
`define REG_Z    4'd9     // Temp Z, flags live in bits 7:4
`define REG_SPH  4'd10
`define REG_SPL  4'd11
`define REG_PCH  4'd12
`define REG_PCL  4'd13

// Address source pairs, also the write-back target
`define PAIR_BC 3'd0
`define PAIR_DE 3'd1
`define PAIR_HL 3'd2
`define PAIR_SP 3'd3
`define PAIR_PC 3'd4
`define PAIR_WZ 3'd5

// Pairwise inc/dec operation
`define IDC_NONE 2'd0
`define IDC_INC  2'd1
`define IDC_DEC  2'd2

// Interrupt controller
`define IE_ADDR          16'hFFFF
`define IRQ_COUNT        5
`define IRQ_INDEX_WIDTH  3
`define IRQ_VECTOR_BASE  16'h0040
`define IRQ_VECTOR_SHIFT 3       // 8 bytes per vector

`endif

//--- bottomPkg.sv
`default_nettype none

package bottomPkg;

	typedef struct packed {
		logic [7:0] hi;
		logic [7:0] lo;
	} bytePair_t;

	// A register pair seen whole for addressing, or as two bytes for loads
	typedef union packed {
		logic [15:0] word;
		bytePair_t   bytes;
	} regPair_t;

endpackage

`default_nettype wire

//--- regFile.sv
`timescale 1ns/100ps
`default_nettype none

`include "bottom_defs.svh"

module regFile import bottomPkg::*; (
	input  logic       CLK,
	input  logic       reset,
	input  logic [3:0] loadSel,
	input  logic [7:0] dlIn,
	input  logic [3:0] readASel,
	input  logic [3:0] readBSel,
	input  logic       wbEn,
	input  logic [2:0] wbSel,
	input  regPair_t   wbValue,
	input  logic       vecLoad,
	input  logic [15:0] vecAddr,
	output logic [7:0] busA,
	output logic [7:0] busB,
	output logic [7:0] accOut,
	output logic [3:0] tempFlags,
	output regPair_t   pairBC,
	output regPair_t   pairDE,
	output regPair_t   pairHL,
	output regPair_t   pairSP,
	output regPair_t   pairPC,
	output regPair_t   pairWZ
);

	logic [7:0] regA;
	regPair_t   regBC, regDE, regHL, regSP, regPC, regWZ;

	function automatic logic [7:0] readByte(input logic [3:0] sel);
		logic [7:0] value;
		case (sel)
			`REG_B:   value = regBC.bytes.hi;
			`REG_C:   value = regBC.bytes.lo;
			`REG_D:   value = regDE.bytes.hi;
			`REG_E:   value = regDE.bytes.lo;
			`REG_H:   value = regHL.bytes.hi;
			`REG_L:   value = regHL.bytes.lo;
			`REG_A:   value = regA;
			`REG_W:   value = regWZ.bytes.hi;
			`REG_Z:   value = regWZ.bytes.lo;
			`REG_SPH: value = regSP.bytes.hi;
			`REG_SPL: value = regSP.bytes.lo;
			`REG_PCH: value = regPC.bytes.hi;
			`REG_PCL: value = regPC.bytes.lo;
			`REG_NONE: value = 8'hFF;   // Undriven bus reads high
			default:  value = 8'hFF;
		endcase
		return value;
	endfunction

	always_comb busA = readByte(readASel);
	always_comb busB = readByte(readBSel);

	always_ff @(posedge CLK) begin
		if (reset) begin
			regA  <= '0;
			regBC <= '0;
			regDE <= '0;
			regHL <= '0;
			regSP <= '0;
			regPC <= '0;
			regWZ <= '0;
		end else begin
			if (wbEn) begin   // Pair write-back from inc/dec
				case (wbSel)
					`PAIR_BC: regBC <= wbValue;
					`PAIR_DE: regDE <= wbValue;
					`PAIR_HL: regHL <= wbValue;
					`PAIR_SP: regSP <= wbValue;
					`PAIR_PC: regPC <= wbValue;
					`PAIR_WZ: regWZ <= wbValue;
					default: ;
				endcase
			end
			// A byte load overrides write-back on the same byte
			case (loadSel)
				`REG_B:   regBC.bytes.hi <= dlIn;
				`REG_C:   regBC.bytes.lo <= dlIn;
				`REG_D:   regDE.bytes.hi <= dlIn;
				`REG_E:   regDE.bytes.lo <= dlIn;
				`REG_H:   regHL.bytes.hi <= dlIn;
				`REG_L:   regHL.bytes.lo <= dlIn;
				`REG_A:   regA <= dlIn;
				`REG_W:   regWZ.bytes.hi <= dlIn;
				`REG_Z:   regWZ.bytes.lo <= dlIn;
				`REG_SPH: regSP.bytes.hi <= dlIn;
				`REG_SPL: regSP.bytes.lo <= dlIn;
				`REG_PCH: regPC.bytes.hi <= dlIn;
				`REG_PCL: regPC.bytes.lo <= dlIn;
				default: ;
			endcase
			if (vecLoad)
				regPC.word <= vecAddr;   // Interrupt vector wins
		end
	end

	assign accOut    = regA;
	assign tempFlags = regWZ.bytes.lo[7:4];   // C, H, N, Z
	assign pairBC    = regBC;
	assign pairDE    = regDE;
	assign pairHL    = regHL;
	assign pairSP    = regSP;
	assign pairPC    = regPC;
	assign pairWZ    = regWZ;

endmodule

`default_nettype wire

//--- addrUnit.sv
`timescale 1ns/100ps
`default_nettype none

`include "bottom_defs.svh"

module addrUnit import bottomPkg::*; (
	input  logic        CLK,
	input  logic        reset,
	input  logic [2:0]  addrSel,
	input  logic [1:0]  incDecOp,
	input  regPair_t    pairBC,
	input  regPair_t    pairDE,
	input  regPair_t    pairHL,
	input  regPair_t    pairSP,
	input  regPair_t    pairPC,
	input  regPair_t    pairWZ,
	output logic [15:0] addr,
	output logic        wbEn,
	output logic [2:0]  wbSel,
	output regPair_t    wbValue
);

	regPair_t srcPair;
	logic     srcValid;

	always_comb begin
		srcValid = 1'b1;
		case (addrSel)
			`PAIR_BC: srcPair = pairBC;
			`PAIR_DE: srcPair = pairDE;
			`PAIR_HL: srcPair = pairHL;
			`PAIR_SP: srcPair = pairSP;
			`PAIR_PC: srcPair = pairPC;
			`PAIR_WZ: srcPair = pairWZ;
			default: begin
				srcPair  = '0;
				srcValid = 1'b0;   // No pair behind this code
			end
		endcase
	end

	// Both halves move as one 16-bit word, wrap is natural
	always_comb begin
		wbValue = srcPair;
		wbEn    = 1'b0;
		case (incDecOp)
			`IDC_INC: begin
				wbValue.word = srcPair.word + 16'd1;
				wbEn         = srcValid;
			end
			`IDC_DEC: begin
				wbValue.word = srcPair.word - 16'd1;
				wbEn         = srcValid;
			end
			`IDC_NONE: wbEn = 1'b0;
			default:   wbEn = 1'b0;
		endcase
	end

	assign wbSel = addrSel;   // Result goes back to its source

	always_ff @(posedge CLK) begin
		if (reset)
			addr <= '0;
		else
			addr <= srcPair.word;   // Pre-update value on the bus
	end

endmodule

`default_nettype wire

//--- operandLogic.sv
`timescale 1ns/100ps
`default_nettype none

module operandLogic (
	input  logic       CLK,
	input  logic       reset,
	input  logic [7:0] busA,
	input  logic [7:0] busB,
	input  logic [7:0] accOut,
	input  logic [5:0] bitCtrl,
	output logic [7:0] alu,
	output logic [7:0] dv,
	output logic       bq4,
	output logic       bq5,
	output logic       bq7
);

	logic [7:0] clrMask;

	// bitCtrl[4] kills the whole operand, bitCtrl[0] enables single-bit clears
	always_comb begin
		clrMask[3:0] = {4{bitCtrl[4]}};
		clrMask[4]   = bitCtrl[4] | (bitCtrl[0] & bitCtrl[1]);
		clrMask[5]   = bitCtrl[4] | (bitCtrl[0] & bitCtrl[5]);
		clrMask[6]   = bitCtrl[4] | (bitCtrl[0] & bitCtrl[2]);
		clrMask[7]   = bitCtrl[4] | (bitCtrl[0] & bitCtrl[3]);
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			alu <= '0;
			dv  <= '0;
			bq4 <= 1'b0;
			bq5 <= 1'b0;
			bq7 <= 1'b0;
		end else begin
			alu <= ~busA;              // Operand 1
			dv  <= ~(busB & ~clrMask); // Operand 2, masked
			bq4 <= accOut[1] | accOut[2] | accOut[3];
			bq5 <= accOut[5] | accOut[6] | accOut[7];
			bq7 <= accOut[4] | accOut[7];
		end
	end

endmodule

`default_nettype wire

//--- irqLogic.sv
`timescale 1ns/100ps
`default_nettype none

`include "bottom_defs.svh"

module irqLogic (
	input  logic                  CLK,
	input  logic                  reset,
	input  logic [15:0]           addr,
	input  logic [7:0]            dlIn,
	input  logic                  ieWrite,
	input  logic                  ieRd,
	input  logic [`IRQ_COUNT-1:0] irqTrig,
	input  logic                  irqDispatch,
	output logic [7:0]            dlOut,
	output logic                  ieSelected,
	output logic                  irqReq,
	output logic [`IRQ_COUNT-1:0] irqAck,
	output logic                  vecLoad,
	output logic [15:0]           vecAddr
);

	logic [`IRQ_COUNT-1:0]       ieReg;
	logic [`IRQ_COUNT-1:0]       pending;
	logic [`IRQ_COUNT-1:0]       eligible;
	logic [`IRQ_COUNT-1:0]       grant;
	logic [`IRQ_INDEX_WIDTH-1:0] grantIdx;

	assign ieSelected = (addr == `IE_ADDR);
	assign eligible   = pending & ieReg;
	assign irqReq     = |eligible;

	// Lowest index has the highest priority
	always_comb begin
		grant    = '0;
		grantIdx = '0;
		for (int i = `IRQ_COUNT - 1; i >= 0; i--) begin
			if (eligible[i]) begin
				grant    = '0;
				grant[i] = 1'b1;
				grantIdx = `IRQ_INDEX_WIDTH'(i);
			end
		end
	end

	assign vecLoad = irqDispatch & irqReq;
	assign vecAddr = `IRQ_VECTOR_BASE + (16'(grantIdx) << `IRQ_VECTOR_SHIFT);

	always_ff @(posedge CLK) begin
		if (reset) begin
			ieReg   <= '0;
			pending <= '0;
			irqAck  <= '0;
			dlOut   <= 8'hFF;
		end else begin
			if (ieWrite && ieSelected)
				ieReg <= dlIn[`IRQ_COUNT-1:0];
			// A fresh trigger on the granted line stays pending
			if (vecLoad)
				pending <= (pending & ~grant) | irqTrig;
			else
				pending <= pending | irqTrig;
			irqAck <= vecLoad ? grant : '0;   // One cycle pulse
			if (ieRd)
				dlOut <= {{(8 - `IRQ_COUNT){1'b0}}, ieReg};
			else
				dlOut <= 8'hFF;   // Idle bus reads high
		end
	end

endmodule

`default_nettype wire

//--- bottom.sv
`timescale 1ns/100ps
`default_nettype none

`include "bottom_defs.svh"

module bottom import bottomPkg::*; (
	input  logic                  CLK,
	input  logic                  reset,
	input  logic [7:0]            dlIn,
	input  logic [3:0]            loadSel,
	input  logic [3:0]            readASel,
	input  logic [3:0]            readBSel,
	input  logic [2:0]            addrSel,
	input  logic [1:0]            incDecOp,
	input  logic [5:0]            bitCtrl,
	input  logic                  ieWrite,
	input  logic                  ieRd,
	input  logic [`IRQ_COUNT-1:0] irqTrig,
	input  logic                  irqDispatch,
	output logic [15:0]           addr,
	output logic [7:0]            alu,
	output logic [7:0]            dv,
	output logic                  bq4,
	output logic                  bq5,
	output logic                  bq7,
	output logic [3:0]            tempFlags,
	output logic [7:0]            dlOut,
	output logic                  ieSelected,
	output logic                  irqReq,
	output logic [`IRQ_COUNT-1:0] irqAck
);

	regPair_t    pairBC, pairDE, pairHL, pairSP, pairPC, pairWZ;
	regPair_t    wbValue;
	logic        wbEn;
	logic [2:0]  wbSel;
	logic [7:0]  busA, busB, accOut;
	logic        vecLoad;
	logic [15:0] vecAddr;

	regFile regFileInst (
		.CLK(CLK), .reset(reset),
		.loadSel(loadSel), .dlIn(dlIn),
		.readASel(readASel), .readBSel(readBSel),
		.wbEn(wbEn), .wbSel(wbSel), .wbValue(wbValue),
		.vecLoad(vecLoad), .vecAddr(vecAddr),
		.busA(busA), .busB(busB), .accOut(accOut), .tempFlags(tempFlags),
		.pairBC(pairBC), .pairDE(pairDE), .pairHL(pairHL),
		.pairSP(pairSP), .pairPC(pairPC), .pairWZ(pairWZ)
	);

	addrUnit addrUnitInst (
		.CLK(CLK), .reset(reset),
		.addrSel(addrSel), .incDecOp(incDecOp),
		.pairBC(pairBC), .pairDE(pairDE), .pairHL(pairHL),
		.pairSP(pairSP), .pairPC(pairPC), .pairWZ(pairWZ),
		.addr(addr), .wbEn(wbEn), .wbSel(wbSel), .wbValue(wbValue)
	);

	operandLogic operandLogicInst (
		.CLK(CLK), .reset(reset),
		.busA(busA), .busB(busB), .accOut(accOut), .bitCtrl(bitCtrl),
		.alu(alu), .dv(dv), .bq4(bq4), .bq5(bq5), .bq7(bq7)
	);

	irqLogic irqLogicInst (
		.CLK(CLK), .reset(reset),
		.addr(addr), .dlIn(dlIn),
		.ieWrite(ieWrite), .ieRd(ieRd),
		.irqTrig(irqTrig), .irqDispatch(irqDispatch),
		.dlOut(dlOut), .ieSelected(ieSelected), .irqReq(irqReq),
		.irqAck(irqAck), .vecLoad(vecLoad), .vecAddr(vecAddr)
	);

endmodule

`default_nettype wire

//--- tb_bottom.sv
`timescale 1ns/100ps
`default_nettype none

`include "bottom_defs.svh"

module tb_bottom;

	logic        CLK, reset;
	logic [7:0]  dlIn;
	logic [3:0]  loadSel, readASel, readBSel;
	logic [2:0]  addrSel;
	logic [1:0]  incDecOp;
	logic [5:0]  bitCtrl;
	logic        ieWrite, ieRd, irqDispatch;
	logic [4:0]  irqTrig, irqAck;
	logic [15:0] addr;
	logic [7:0]  alu, dv, dlOut;
	logic        bq4, bq5, bq7, ieSelected, irqReq;
	logic [3:0]  tempFlags;

	logic [7:0]  mReg [0:15];   // Model bytes, indexed by select code
	logic [4:0]  mIe, mPend;
	logic [15:0] mAddr;
	logic [31:0] lcgState = 32'h717b;
	int          errorCount = 0;
	int          cycleCount = 0;
	logic        timedOut = 1'b0;

	bottom bottom_inst (.*);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// Lo byte code always follows the hi byte code
	function automatic logic [3:0] pairHigh(input logic [2:0] sel);
		case (sel)
			`PAIR_BC: return `REG_B;
			`PAIR_DE: return `REG_D;
			`PAIR_HL: return `REG_H;
			`PAIR_SP: return `REG_SPH;
			`PAIR_PC: return `REG_PCH;
			default:  return `REG_W;
		endcase
	endfunction

	function automatic logic [15:0] modelPair(input logic [2:0] sel);
		return {mReg[pairHigh(sel)], mReg[pairHigh(sel) + 4'd1]};
	endfunction

	function automatic logic [7:0] modelRead(input logic [3:0] sel);
		if (sel == `REG_NONE || sel > `REG_PCL)
			return 8'hFF;   // Nothing drives the bus
		return mReg[sel];
	endfunction

	function automatic logic [7:0] clearMask(input logic [5:0] ctrl);
		logic [7:0] mask;
		mask = ctrl[4] ? 8'hFF : 8'h00;
		if (ctrl[0]) begin   // Single-bit clears of bits 7:4
			mask[4] = mask[4] | ctrl[1];
			mask[5] = mask[5] | ctrl[5];
			mask[6] = mask[6] | ctrl[2];
			mask[7] = mask[7] | ctrl[3];
		end
		return mask;
	endfunction

	function automatic logic [2:0] lowestIndex(input logic [4:0] lines);
		logic [2:0] idx;
		idx = 3'd0;
		while (idx < 3'd4 && !lines[idx])
			idx++;
		return idx;
	endfunction

	task automatic reportMismatch(input string msg);
		errorCount++;
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
	endtask

	task automatic writeModelPair(input logic [2:0] sel, input logic [15:0] value);
		mReg[pairHigh(sel)] = value[15:8];
		mReg[pairHigh(sel) + 4'd1] = value[7:0];
	endtask

	task automatic driveIdle();
		dlIn        = 8'h00;
		loadSel     = `REG_NONE;
		readASel    = `REG_NONE;
		readBSel    = `REG_NONE;
		addrSel     = `PAIR_BC;
		incDecOp    = `IDC_NONE;
		bitCtrl     = 6'd0;
		ieWrite     = 1'b0;
		ieRd        = 1'b0;
		irqTrig     = 5'd0;
		irqDispatch = 1'b0;
	endtask

	// One rising edge predicted by the model, outputs compared at the falling edge
	task automatic stepCycle();
		logic [15:0] src;
		logic [7:0]  eAlu, eDv, eDlOut, acc;
		logic [4:0]  eAck;
		logic [2:0]  eBq, gIdx;
		src    = modelPair(addrSel);
		acc    = mReg[`REG_A];
		eAlu   = ~modelRead(readASel);
		eDv    = ~(modelRead(readBSel) & ~clearMask(bitCtrl));
		eBq    = {acc[1] | acc[2] | acc[3], acc[5] | acc[6] | acc[7], acc[4] | acc[7]};
		eDlOut = ieRd ? {3'b000, mIe} : 8'hFF;
		gIdx   = lowestIndex(mPend & mIe);
		eAck   = 5'd0;
		if (irqDispatch && (mPend & mIe) != 5'd0)
			eAck = 5'b00001 << gIdx;
		if (ieWrite && mAddr == `IE_ADDR)
			mIe = dlIn[4:0];
		mAddr = src;
		if (incDecOp == `IDC_INC)
			writeModelPair(addrSel, src + 16'd1);
		else if (incDecOp == `IDC_DEC)
			writeModelPair(addrSel, src - 16'd1);
		if (loadSel != `REG_NONE && loadSel <= `REG_PCL)
			mReg[loadSel] = dlIn;   // Byte load beats write-back
		if (eAck != 5'd0)
			writeModelPair(`PAIR_PC, 16'h0040 + {10'd0, gIdx, 3'b000});
		mPend = (mPend & ~eAck) | irqTrig;
		@(posedge CLK);
		@(negedge CLK);
		cycleCount++;
		if (addr !== mAddr)
			reportMismatch($sformatf("addr %h, model %h", addr, mAddr));
		if (alu !== eAlu || dv !== eDv)
			reportMismatch($sformatf("alu/dv %h/%h, model %h/%h", alu, dv, eAlu, eDv));
		if ({bq4, bq5, bq7} !== eBq)
			reportMismatch($sformatf("bq4/5/7 %b%b%b, model %b", bq4, bq5, bq7, eBq));
		if (tempFlags !== mReg[`REG_Z][7:4])
			reportMismatch($sformatf("tempFlags %h, model %h", tempFlags, mReg[`REG_Z][7:4]));
		if (dlOut !== eDlOut)
			reportMismatch($sformatf("dlOut %h, model %h", dlOut, eDlOut));
		if (ieSelected !== (mAddr == `IE_ADDR) || irqReq !== |(mPend & mIe))
			reportMismatch($sformatf("ieSelected/irqReq %b/%b wrong", ieSelected, irqReq));
		if (irqAck !== eAck)
			reportMismatch($sformatf("irqAck %b, model %b", irqAck, eAck));
	endtask

	task automatic loadPair(input logic [2:0] sel, input logic [15:0] value);
		driveIdle();
		loadSel = pairHigh(sel);
		dlIn    = value[15:8];
		stepCycle();
		loadSel = pairHigh(sel) + 4'd1;
		dlIn    = value[7:0];
		stepCycle();
		driveIdle();
	endtask

	task automatic waitForIrqReq(input int limit);
		int count;
		count = 0;
		while (irqReq !== 1'b1 && count < limit) begin
			stepCycle();
			count++;
		end
		if (irqReq !== 1'b1) begin
			$display("Timeout at %0t ns: irqReq stayed low for %0d cycles", $time, limit);
			timedOut = 1'b1;
			errorCount++;
		end
	endtask

	task automatic finishTest(input string name, input int startErrors);
		$display("Test %s done: %0d errors", name, errorCount - startErrors);
	endtask

	initial begin
		logic [31:0] r;
		logic [7:0]  data;
		logic [3:0]  sel;
		logic [2:0]  idx;
		logic [15:0] expAddr;
		int          startErrors;
		driveIdle();
		reset = 1'b1;
		for (int i = 0; i < 16; i++)
			mReg[i] = 8'h00;
		mIe   = 5'd0;
		mPend = 5'd0;
		mAddr = 16'h0000;
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		reset = 1'b0;
		if (addr !== 16'h0000 || irqAck !== 5'd0 || irqReq !== 1'b0 || dlOut !== 8'hFF)
			reportMismatch("outputs not at their reset values");

		startErrors = errorCount;
		for (int i = 0; i < 40; i++) begin
			r       = nextRand();
			sel     = 4'(r[23:16] % 8'd13) + 4'd1;
			data    = r[31:24];
			loadSel = sel;
			dlIn    = data;
			stepCycle();
			driveIdle();
			readASel = sel;
			readBSel = sel;
			stepCycle();
			if (alu !== ~data || dv !== ~data)
				reportMismatch($sformatf("reg %0d reads %h/%h after load %h", sel, alu, dv, data));
			if (sel == `REG_Z && tempFlags !== data[7:4])
				reportMismatch($sformatf("tempFlags %h after Z load %h", tempFlags, data));
			driveIdle();
		end
		finishTest("register loads", startErrors);

		startErrors = errorCount;
		r = nextRand();
		loadPair(`PAIR_BC, r[31:16]);
		for (int i = 0; i < 30; i++) begin
			r        = nextRand();
			loadSel  = `REG_A;   // Hints follow the A of the cycle before
			dlIn     = r[31:24];
			readBSel = `REG_B;
			bitCtrl  = r[21:16];
			stepCycle();
			if (dv !== ~(mReg[`REG_B] & ~clearMask(r[21:16])))
				reportMismatch($sformatf("dv %h with bitCtrl %b", dv, r[21:16]));
		end
		driveIdle();
		finishTest("bit masking", startErrors);

		startErrors = errorCount;
		loadPair(`PAIR_HL, 16'hFFFF);
		loadPair(`PAIR_SP, 16'h0000);
		addrSel  = `PAIR_HL;
		incDecOp = `IDC_INC;
		stepCycle();
		addrSel  = `PAIR_SP;
		incDecOp = `IDC_DEC;
		stepCycle();
		incDecOp = `IDC_NONE;
		stepCycle();
		if (addr !== 16'hFFFF)
			reportMismatch($sformatf("SP after 0000 decrement is %h", addr));
		addrSel = `PAIR_HL;
		stepCycle();
		if (addr !== 16'h0000)
			reportMismatch($sformatf("HL after FFFF increment is %h", addr));
		for (int i = 0; i < 60; i++) begin
			r        = nextRand();
			addrSel  = 3'(r[23:16] % 8'd6);
			incDecOp = 2'(r[31:24] % 8'd3);
			expAddr  = modelPair(addrSel);
			stepCycle();
			if (addr !== expAddr)
				reportMismatch($sformatf("pair %0d drove addr %h, expected %h", addrSel, addr, expAddr));
		end
		driveIdle();
		finishTest("address unit", startErrors);

		startErrors = errorCount;
		loadPair(`PAIR_WZ, `IE_ADDR);
		addrSel = `PAIR_WZ;
		stepCycle();
		if (ieSelected !== 1'b1)
			reportMismatch("ieSelected low with addr at FFFF");
		r       = nextRand();
		data    = r[31:24];
		ieWrite = 1'b1;
		dlIn    = data;
		stepCycle();
		ieWrite = 1'b0;
		ieRd    = 1'b1;
		stepCycle();
		if (dlOut !== {3'b000, data[4:0]})
			reportMismatch($sformatf("IE reads %h after writing %h", dlOut, data));
		ieRd    = 1'b0;
		addrSel = `PAIR_BC;
		stepCycle();
		if (dlOut !== 8'hFF || ieSelected !== (mAddr == `IE_ADDR))
			reportMismatch($sformatf("idle dlOut %h, ieSelected %b", dlOut, ieSelected));
		finishTest("IE access", startErrors);

		startErrors = errorCount;
		for (int i = 0; i < 25; i++) begin
			driveIdle();
			addrSel = `PAIR_WZ;   // Back onto the IE address
			stepCycle();
			r       = nextRand();
			ieWrite = 1'b1;
			dlIn    = r[31:24];
			stepCycle();
			ieWrite = 1'b0;
			r       = nextRand();
			irqTrig = r[20:16];
			stepCycle();
			irqTrig = 5'd0;
			if ((mPend & mIe) != 5'd0) begin
				waitForIrqReq(8);
				idx         = lowestIndex(mPend & mIe);
				expAddr     = 16'h0040 + {10'd0, idx, 3'b000};
				irqDispatch = 1'b1;
				stepCycle();
				if (irqAck !== (5'b00001 << idx))
					reportMismatch($sformatf("irqAck %b, expected line %0d", irqAck, idx));
			end else begin
				expAddr     = modelPair(`PAIR_PC);   // Nothing eligible, PC holds
				irqDispatch = 1'b1;
				stepCycle();
				if (irqAck !== 5'd0)
					reportMismatch($sformatf("irqAck %b with nothing eligible", irqAck));
			end
			irqDispatch = 1'b0;
			addrSel     = `PAIR_PC;
			stepCycle();
			if (addr !== expAddr)
				reportMismatch($sformatf("PC %h after dispatch, expected %h", addr, expAddr));
		end
		driveIdle();
		finishTest("interrupts", startErrors);

		$display("Totals: %0d cycles checked, %0d errors", cycleCount, errorCount);
		if (errorCount == 0 && !timedOut)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
bottomPkg.sv
regFile.sv
addrUnit.sv
operandLogic.sv
irqLogic.sv
bottom.sv
tb_bottom.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_bottom -o tb_bottom_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/tb_bottom_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^RESULT: PASS$"; then
	exit 0
fi
exit 1
